// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary -Wno-fatal
TOP       ?= ice51_tb
FILELIST  ?= ice51.f
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== ice51.f ====
rtl/ice51_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/code_ram.sv
rtl/cpu_control.sv
rtl/cpu_datapath.sv
rtl/ice51.sv
tb/ice51_tb.sv

// ==== rtl/code_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module code_ram (
   input  wire                            i_clk,
   input  wire                            i_nrst,
   input  wire                            i_byte_vld,
   input  wire  [7:0]                     i_byte,
   input  wire  [ice51_pkg::CODE_AW-1:0]  i_raddr,
   output logic [7:0]                     o_rdata,
   output logic                           o_load_done
);

   logic [7:0]                    mem [ice51_pkg::CODE_DEPTH];
   logic [ice51_pkg::CODE_AW-1:0] load_cnt;
   ice51_pkg::code_wr_t           wr;

   // loader write closed once the image is in
   assign wr = {i_byte_vld & ~o_load_done, load_cnt, i_byte};

   always_ff @(posedge i_clk) begin
      if (wr.we)
         mem[wr.addr] <= wr.data;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_cnt    <= '0;
         o_load_done <= 1'b0;
      end else if (wr.we) begin
         load_cnt <= load_cnt + 1'b1;
         if (load_cnt == ice51_pkg::CODE_LAST)
            o_load_done <= 1'b1;  // sticky until reset
      end
   end

   assign o_rdata = mem[i_raddr];  // async fetch port

endmodule

`default_nettype wire

// ==== rtl/cpu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
   input  wire                             i_clk,
   input  wire                             i_nrst,
   input  wire                             i_load_done,
   input  wire  [7:0]                      i_code,
   input  wire ice51_pkg::dp_flags_t       i_flags,
   output logic [ice51_pkg::CODE_AW-1:0]   o_code_addr,
   output ice51_pkg::exec_t                o_exec
);

   logic [2:0]                    state;
   logic [ice51_pkg::CODE_AW-1:0] pc;
   logic [ice51_pkg::CODE_AW-1:0] pc_exec;
   ice51_pkg::opcode_u            op_q;
   logic [7:0]                    op1_q;
   logic [7:0]                    op2_q;
   logic [15:0]                   ljmp_tgt;
   logic                          taken;
   logic                          tbl_fetch;

   // instruction length in bytes
   function automatic logic [1:0] op_len(ice51_pkg::opcode_u op);
      logic [1:0] len;
      len = 2'd1;
      case (op.full)
         ice51_pkg::OP_LJMP,
         ice51_pkg::OP_MOVDP:  len = 2'd3;
         ice51_pkg::OP_ADDAI,
         ice51_pkg::OP_ADDCI,
         ice51_pkg::OP_SUBBAI,
         ice51_pkg::OP_ANLAI,
         ice51_pkg::OP_ORLAI,
         ice51_pkg::OP_XRLAI,
         ice51_pkg::OP_MOVAI,
         ice51_pkg::OP_SJMP,
         ice51_pkg::OP_JZ,
         ice51_pkg::OP_JNZ,
         ice51_pkg::OP_JC,
         ice51_pkg::OP_JNC,
         ice51_pkg::OP_MOVC:   len = 2'd2;  // movc spends its second cycle on the table
         default: ;
      endcase
      if ((op.rf.grp == ice51_pkg::OPG_MOVRI) || (op.rf.grp == ice51_pkg::OPG_DJNZR))
         len = 2'd2;
      return len;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // fetch address

   assign tbl_fetch   = (state == ice51_pkg::ST_DECODE1) && (op_q.full == ice51_pkg::OP_MOVC);
   assign o_code_addr = tbl_fetch ? i_flags.tbl_addr : pc;

   ////////////////////////////////////////////////////////////////////////////
   // branch decision with pc already past the instruction

   always_comb begin
      case (op_q.full)
         ice51_pkg::OP_SJMP: taken = 1'b1;
         ice51_pkg::OP_JZ:   taken = i_flags.acc_zero;
         ice51_pkg::OP_JNZ:  taken = ~i_flags.acc_zero;
         ice51_pkg::OP_JC:   taken = i_flags.carry;
         ice51_pkg::OP_JNC:  taken = ~i_flags.carry;
         default: taken = (op_q.rf.grp == ice51_pkg::OPG_DJNZR) & i_flags.djnz_nonzero;
      endcase
   end

   assign ljmp_tgt = {op1_q, op2_q};  // high byte first
   assign pc_exec  = (op_q.full == ice51_pkg::OP_LJMP) ? ljmp_tgt[ice51_pkg::CODE_AW-1:0] :
                     taken ? pc + op1_q[ice51_pkg::CODE_AW-1:0] :  // signed rel wraps
                             pc;

   ////////////////////////////////////////////////////////////////////////////
   // sequencer

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ice51_pkg::ST_FETCH;
         pc    <= '0;
         op_q  <= '0;
         op1_q <= '0;
         op2_q <= '0;
      end else begin
         case (state)
            ice51_pkg::ST_FETCH: if (i_load_done)
               state <= ice51_pkg::ST_DECODE0;
            ice51_pkg::ST_DECODE0: begin
               op_q  <= i_code;
               pc    <= pc + 1'b1;
               state <= (op_len(i_code) == 2'd1) ? ice51_pkg::ST_EXECUTE :
                                                   ice51_pkg::ST_DECODE1;
            end
            ice51_pkg::ST_DECODE1: begin
               op1_q <= i_code;
               if (!tbl_fetch)
                  pc <= pc + 1'b1;
               state <= (op_len(op_q) == 2'd3) ? ice51_pkg::ST_DECODE2 :
                                                 ice51_pkg::ST_EXECUTE;
            end
            ice51_pkg::ST_DECODE2: begin
               op2_q <= i_code;
               pc    <= pc + 1'b1;
               state <= ice51_pkg::ST_EXECUTE;
            end
            ice51_pkg::ST_EXECUTE: begin
               pc    <= pc_exec;
               state <= ice51_pkg::ST_FETCH;
            end
            default: state <= ice51_pkg::ST_FETCH;
         endcase
      end
   end

   assign o_exec = {state == ice51_pkg::ST_EXECUTE, op_q, op1_q, op2_q};

endmodule

`default_nettype wire

// ==== rtl/cpu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath (
   input  wire                        i_clk,
   input  wire                        i_nrst,
   input  wire ice51_pkg::exec_t      i_exec,
   input  wire                        i_tx_busy,
   output ice51_pkg::dp_flags_t       o_flags,
   output ice51_pkg::tx_req_t         o_tx_req
);

   ice51_pkg::opcode_u op;
   logic [7:0]         acc;
   logic [7:0]         acc_nxt;
   logic               carry;
   logic               carry_nxt;
   logic [15:0]        dptr;
   logic [7:0]         r [8];
   logic [7:0]         rn_val;
   logic [7:0]         rn_wdata;
   logic               rn_we;
   logic [7:0]         alu_b;
   logic               cin;
   logic [8:0]         sum;
   logic [8:0]         diff;
   logic [15:0]        tbl_sum;

   assign op     = i_exec.op;
   assign rn_val = r[op.rf.rn];

   ////////////////////////////////////////////////////////////////////////////
   // alu

   // bit 3 marks the Rn forms of add, addc and subb
   assign alu_b = op.full[3] ? rn_val : i_exec.op1;
   assign cin   = carry & ((op.full == ice51_pkg::OP_ADDCI) ||
                           (op.rf.grp == ice51_pkg::OPG_ADDCR));
   assign sum   = {1'b0, acc} + {1'b0, alu_b} + {8'd0, cin};
   assign diff  = {1'b0, acc} - {1'b0, alu_b} - {8'd0, carry};  // bit 8 is the borrow

   always_comb begin
      acc_nxt   = acc;
      carry_nxt = carry;
      case (op.full)
         ice51_pkg::OP_INCA:  acc_nxt = acc + 8'd1;
         ice51_pkg::OP_DECA:  acc_nxt = acc - 8'd1;
         ice51_pkg::OP_ADDAI,
         ice51_pkg::OP_ADDCI: begin
            acc_nxt   = sum[7:0];
            carry_nxt = sum[8];
         end
         ice51_pkg::OP_SUBBAI: begin
            acc_nxt   = diff[7:0];
            carry_nxt = diff[8];
         end
         ice51_pkg::OP_ANLAI: acc_nxt = acc & i_exec.op1;
         ice51_pkg::OP_ORLAI: acc_nxt = acc | i_exec.op1;
         ice51_pkg::OP_XRLAI: acc_nxt = acc ^ i_exec.op1;
         ice51_pkg::OP_CPLA:  acc_nxt = ~acc;
         ice51_pkg::OP_CLRA:  acc_nxt = 8'd0;
         ice51_pkg::OP_MOVAI,
         ice51_pkg::OP_MOVC:  acc_nxt = i_exec.op1;  // movc byte arrives as op1
         ice51_pkg::OP_RL:    acc_nxt = {acc[6:0], acc[7]};
         ice51_pkg::OP_RLC: begin
            acc_nxt   = {acc[6:0], carry};
            carry_nxt = acc[7];
         end
         ice51_pkg::OP_RRC: begin
            acc_nxt   = {carry, acc[7:1]};
            carry_nxt = acc[0];
         end
         ice51_pkg::OP_CLRC:  carry_nxt = 1'b0;
         ice51_pkg::OP_SETBC: carry_nxt = 1'b1;
         // tx status read with zero for other addresses
         ice51_pkg::OP_MOVXAD:
            acc_nxt = {7'd0, i_tx_busy & (dptr == ice51_pkg::UART_TX_STAT_ADDR)};
         default: ;
      endcase
      case (op.rf.grp)
         ice51_pkg::OPG_ADDR,
         ice51_pkg::OPG_ADDCR: begin
            acc_nxt   = sum[7:0];
            carry_nxt = sum[8];
         end
         ice51_pkg::OPG_SUBBR: begin
            acc_nxt   = diff[7:0];
            carry_nxt = diff[8];
         end
         ice51_pkg::OPG_MOVAR: acc_nxt = rn_val;
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // register file write

   always_comb begin
      rn_we    = 1'b1;
      rn_wdata = rn_val;
      case (op.rf.grp)
         ice51_pkg::OPG_MOVRI: rn_wdata = i_exec.op1;
         ice51_pkg::OPG_MOVRA: rn_wdata = acc;
         ice51_pkg::OPG_INCR:  rn_wdata = rn_val + 8'd1;
         ice51_pkg::OPG_DECR,
         ice51_pkg::OPG_DJNZR: rn_wdata = rn_val - 8'd1;
         default: rn_we = 1'b0;
      endcase
   end

   // architectural state moves only on the execute strobe
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         for (int i = 0; i < 8; i++)
            r[i] <= '0;
      end else if (i_exec.stb) begin
         acc   <= acc_nxt;
         carry <= carry_nxt;
         if (op.full == ice51_pkg::OP_MOVDP)
            dptr <= {i_exec.op1, i_exec.op2};
         if (rn_we)
            r[op.rf.rn] <= rn_wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // flags and tx mapping

   assign tbl_sum = {8'd0, acc} + dptr;
   assign o_flags = {acc == 8'd0, carry, rn_val != 8'd1,  // djnz sees Rn before decrement
                     tbl_sum[ice51_pkg::CODE_AW-1:0]};

   assign o_tx_req = {i_exec.stb && (op.full == ice51_pkg::OP_MOVXDA) &&
                      (dptr == ice51_pkg::UART_TX_DATA_ADDR), acc};

endmodule

`default_nettype wire

// ==== rtl/ice51.sv ====
`timescale 1ns/100ps
`default_nettype none

module ice51 (
   input  wire  i_clk,
   input  wire  i_nrst,
   input  wire  i_uart_rx,
   output logic o_uart_tx
);

   logic                          rx_vld;
   logic [7:0]                    rx_byte;
   logic                          load_done;
   logic [ice51_pkg::CODE_AW-1:0] code_addr;
   logic [7:0]                    code_data;
   ice51_pkg::exec_t              exec;
   ice51_pkg::dp_flags_t          flags;
   ice51_pkg::tx_req_t            tx_req;
   logic                          tx_busy;

   uart_rx u_uart_rx (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_uart_rx),
      .o_byte_vld  (rx_vld),
      .o_byte      (rx_byte)
   );

   code_ram u_code_ram (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_byte_vld  (rx_vld),
      .i_byte      (rx_byte),
      .i_raddr     (code_addr),
      .o_rdata     (code_data),
      .o_load_done (load_done)
   );

   cpu_control u_cpu_control (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code      (code_data),
      .i_flags     (flags),
      .o_code_addr (code_addr),
      .o_exec      (exec)
   );

   cpu_datapath u_cpu_datapath (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_exec      (exec),
      .i_tx_busy   (tx_busy),
      .o_flags     (flags),
      .o_tx_req    (tx_req)
   );

   uart_tx u_uart_tx (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_req       (tx_req),
      .o_tx        (o_uart_tx),
      .o_busy      (tx_busy)
   );

endmodule

`default_nettype wire

// ==== rtl/ice51_pkg.sv ====
`default_nettype none

package ice51_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // uart timing

   localparam int UART_CLKS_PER_BIT = 104;
   localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT + 1);
   localparam logic [UART_CNT_W-1:0] UART_FULL_CNT = UART_CNT_W'(UART_CLKS_PER_BIT);
   localparam logic [UART_CNT_W-1:0] UART_HALF_CNT = UART_CNT_W'(UART_CLKS_PER_BIT / 2);

   localparam logic [1:0] RX_IDLE  = 2'd0;
   localparam logic [1:0] RX_START = 2'd1;
   localparam logic [1:0] RX_DATA  = 2'd2;
   localparam logic [1:0] RX_STOP  = 2'd3;

   localparam logic [1:0] TX_IDLE  = 2'd0;
   localparam logic [1:0] TX_START = 2'd1;
   localparam logic [1:0] TX_SEND  = 2'd2;

   ////////////////////////////////////////////////////////////////////////////
   // code memory and io map

   localparam int CODE_AW    = 8;
   localparam int CODE_DEPTH = 2 ** CODE_AW;
   localparam logic [CODE_AW-1:0] CODE_LAST = CODE_AW'(CODE_DEPTH - 1);

   localparam logic [15:0] UART_TX_DATA_ADDR = 16'h0201;
   localparam logic [15:0] UART_TX_STAT_ADDR = 16'h0200;

   // sequencer
   localparam logic [2:0] ST_FETCH   = 3'd0;
   localparam logic [2:0] ST_DECODE0 = 3'd1;
   localparam logic [2:0] ST_DECODE1 = 3'd2;
   localparam logic [2:0] ST_DECODE2 = 3'd3;
   localparam logic [2:0] ST_EXECUTE = 3'd4;

   ////////////////////////////////////////////////////////////////////////////
   // opcodes

   localparam logic [7:0] OP_LJMP   = 8'h02;
   localparam logic [7:0] OP_INCA   = 8'h04;
   localparam logic [7:0] OP_RRC    = 8'h13;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_RL     = 8'h23;
   localparam logic [7:0] OP_ADDAI  = 8'h24;
   localparam logic [7:0] OP_RLC    = 8'h33;
   localparam logic [7:0] OP_ADDCI  = 8'h34;
   localparam logic [7:0] OP_JC     = 8'h40;
   localparam logic [7:0] OP_ORLAI  = 8'h44;
   localparam logic [7:0] OP_JNC    = 8'h50;
   localparam logic [7:0] OP_ANLAI  = 8'h54;
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_XRLAI  = 8'h64;
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74;
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_MOVDP  = 8'h90;  // mov dptr,#imm16
   localparam logic [7:0] OP_MOVC   = 8'h93;  // movc a,@a+dptr
   localparam logic [7:0] OP_SUBBAI = 8'h94;
   localparam logic [7:0] OP_CLRC   = 8'hC3;
   localparam logic [7:0] OP_SETBC  = 8'hD3;
   localparam logic [7:0] OP_MOVXAD = 8'hE0;  // movx a,@dptr
   localparam logic [7:0] OP_CLRA   = 8'hE4;
   localparam logic [7:0] OP_MOVXDA = 8'hF0;  // movx @dptr,a
   localparam logic [7:0] OP_CPLA   = 8'hF4;

   // upper five opcode bits of the Rn forms
   localparam logic [4:0] OPG_INCR  = 5'h01;
   localparam logic [4:0] OPG_DECR  = 5'h03;
   localparam logic [4:0] OPG_ADDR  = 5'h05;
   localparam logic [4:0] OPG_ADDCR = 5'h07;
   localparam logic [4:0] OPG_MOVRI = 5'h0F;
   localparam logic [4:0] OPG_SUBBR = 5'h13;
   localparam logic [4:0] OPG_DJNZR = 5'h1B;
   localparam logic [4:0] OPG_MOVAR = 5'h1D;
   localparam logic [4:0] OPG_MOVRA = 5'h1F;

   ////////////////////////////////////////////////////////////////////////////
   // shared types

   typedef union packed {
      logic [7:0] full;
      struct packed {
         logic [4:0] grp;
         logic [2:0] rn;
      } rf;
   } opcode_u;

   typedef struct packed {
      logic               we;
      logic [CODE_AW-1:0] addr;
      logic [7:0]         data;
   } code_wr_t;

   typedef struct packed {
      logic       stb;
      opcode_u    op;
      logic [7:0] op1;
      logic [7:0] op2;
   } exec_t;

   typedef struct packed {
      logic               acc_zero;
      logic               carry;
      logic               djnz_nonzero;
      logic [CODE_AW-1:0] tbl_addr;
   } dp_flags_t;

   typedef struct packed {
      logic       stb;
      logic [7:0] data;
   } tx_req_t;

endpackage

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
   input  wire         i_clk,
   input  wire         i_nrst,
   input  wire         i_rx,
   output logic        o_byte_vld,
   output logic  [7:0] o_byte
);

   logic                              rx_meta;
   logic                              rx_sync;
   logic [1:0]                        state;
   logic [ice51_pkg::UART_CNT_W-1:0] cnt;
   logic [7:0]                        shreg;
   logic                              half_end;
   logic                              bit_end;

   // two flop synchronizer for a line that idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   assign half_end = (state == ice51_pkg::RX_START) && (cnt == ice51_pkg::UART_HALF_CNT);
   assign bit_end  = (cnt == ice51_pkg::UART_FULL_CNT);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         cnt <= '0;
      else if ((state == ice51_pkg::RX_IDLE) || half_end || bit_end)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= ice51_pkg::RX_IDLE;
         shreg      <= '0;
         o_byte_vld <= 1'b0;
      end else begin
         o_byte_vld <= 1'b0;
         case (state)
            ice51_pkg::RX_IDLE: if (!rx_sync) begin
               state <= ice51_pkg::RX_START;
               shreg <= 8'h80;  // marker falls out after 8 bits
            end
            // drop glitches at mid start bit
            ice51_pkg::RX_START: if (half_end)
               state <= rx_sync ? ice51_pkg::RX_IDLE : ice51_pkg::RX_DATA;
            ice51_pkg::RX_DATA: if (bit_end) begin
               shreg <= {rx_sync, shreg[7:1]};  // lsb first
               if (shreg[0])
                  state <= ice51_pkg::RX_STOP;
            end
            default: if (bit_end) begin
               state      <= ice51_pkg::RX_IDLE;
               o_byte_vld <= 1'b1;
            end
         endcase
      end
   end

   assign o_byte = shreg;

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
   input  wire                  i_clk,
   input  wire                  i_nrst,
   input  wire ice51_pkg::tx_req_t i_req,
   output logic                 o_tx,
   output logic                 o_busy
);

   logic [1:0]                        state;
   logic [ice51_pkg::UART_CNT_W-1:0] cnt;
   logic [3:0]                        bit_cnt;
   logic [7:0]                        shreg;
   logic                              bit_end;

   assign bit_end = (cnt == ice51_pkg::UART_FULL_CNT);

   // bit timer held at zero while idle
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         cnt <= '0;
      else if ((state == ice51_pkg::TX_IDLE) || bit_end)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= ice51_pkg::TX_IDLE;
         bit_cnt <= '0;
         shreg   <= 8'hFF;
      end else begin
         case (state)
            ice51_pkg::TX_IDLE: begin
               bit_cnt <= '0;
               if (i_req.stb) begin  // only accepted here
                  shreg <= i_req.data;
                  state <= ice51_pkg::TX_START;
               end
            end
            ice51_pkg::TX_START: if (bit_end)
               state <= ice51_pkg::TX_SEND;
            ice51_pkg::TX_SEND: if (bit_end) begin
               shreg   <= {1'b1, shreg[7:1]};  // ones behind become the stop bit
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd8)
                  state <= ice51_pkg::TX_IDLE;
            end
            default: state <= ice51_pkg::TX_IDLE;
         endcase
      end
   end

   assign o_tx   = (state == ice51_pkg::TX_IDLE)  ? 1'b1 :
                   (state == ice51_pkg::TX_START) ? 1'b0 : shreg[0];
   assign o_busy = (state != ice51_pkg::TX_IDLE);

endmodule

`default_nettype wire

// ==== tb/ice51_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ice51_tb;

   localparam int BIT_CLKS  = ice51_pkg::UART_CLKS_PER_BIT + 1;  // one uart bit in clocks
   localparam int HALF_CLKS = BIT_CLKS / 2;
   localparam int PROG_LEN  = ice51_pkg::CODE_DEPTH;
   localparam int VEC_LEN   = PROG_LEN + 1 + 64;
   localparam int IDLE_TAIL = 4000;     // quiet time after the last frame

   logic       clk = 1'b0;
   logic       nrst;
   logic       uart_rx;
   wire        uart_tx;
   logic [7:0] vec [VEC_LEN];           // program, count, expected bytes
   int         n_exp;
   longint     cycles = 0;
   longint     limit = 0;

   ////////////////////////////////////////////////////////////////////////////
   // clock, DUT and run limit

   always #50 clk = ~clk;

   ice51 i_ice51 (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if ((limit != 0) && (cycles >= limit))
         fail_run("timeout, the program did not finish within the cycle limit");
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         fail_run($sformatf("Mismatch %s expected 0x%02h actual 0x%02h", name, exp, act));
   endtask

   // called just after a rising edge plus the drive delay
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
      for (int i = 0; i < 10; i++) begin
         uart_rx = frame[i];
         repeat (BIT_CLKS) @(posedge clk);
         #10;
      end
   endtask

   task automatic send_program;
      @(posedge clk);
      #10;
      for (int a = 0; a < PROG_LEN; a++)
         send_byte(vec[a]);
   endtask

   // tx line sampled on falling edges between its updates
   task automatic receive_byte(output logic [7:0] b);
      @(negedge clk);
      while (uart_tx)
         @(negedge clk);
      repeat (HALF_CLKS) @(negedge clk);
      if (uart_tx)
         fail_run("start bit on the tx line did not stay low");
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CLKS) @(negedge clk);
         b[i] = uart_tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      if (!uart_tx)
         fail_run("framing error, the stop bit on the tx line is low");
   endtask

   task automatic watch_output;
      logic [7:0] got;
      for (int i = 0; i < n_exp; i++) begin
         receive_byte(got);
         check($sformatf("tx_byte_%0d", i), vec[PROG_LEN + 1 + i], got);
      end
      // program is parked in its halt loop now
      repeat (IDLE_TAIL) begin
         @(negedge clk);
         if (!uart_tx)
            fail_run("an extra frame followed the expected bytes");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      nrst    = 1'b0;
      uart_rx = 1'b1;
      $readmemh("tb/ice51_tb_input.hex", vec);
      n_exp = int'(vec[PROG_LEN]);
      if ((n_exp == 0) || (n_exp > VEC_LEN - PROG_LEN - 1))
         fail_run("the input file holds no valid expected byte count");
      // twice the load time plus a budget per printed byte
      limit = 2 * (longint'(PROG_LEN) * 10 * BIT_CLKS + longint'(n_exp) * 2000);

      repeat (8) @(posedge clk);
      check("idle_in_reset", 8'h01, {7'd0, uart_tx});
      #10;
      nrst = 1'b1;

      fork
         send_program();
         watch_output();
      join

      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/ice51_tb_input.hex ====
// entries 0x000-0x0FF: program bytes for code addresses 0x00-0x0FF
// entry 0x100: expected byte count N, then the N expected tx bytes in order
// 00 logic ops, 15 rotates, 26 add/addc, 3B subb, 4A branches/ljmp/sjmp
74 C3 54 0F 44 A0 64 3C F4 FF 90 02 00 E0 70 FD
EF 90 02 01 F0 23 D3 13 33 33 FF 90 02 00 E0 70
FD EF 90 02 01 F0 E4 24 10 24 F5 34 20 34 01 FF
90 02 00 E0 70 FD EF 90 02 01 F0 D3 94 30 FF 90
02 00 E0 70 FD EF 90 02 01 F0 74 FF 04 60 02 74
EE 70 01 14 24 03 70 02 74 EE 40 02 74 DD 50 01
04 C3 50 02 74 CC 40 01 04 60 01 04 02 00 70 04
80 03 04 80 02 80 FB FF 90 02 00 E0 70 FD EF 90
// 83 registers, B2 djnz loop, C3 table loop, D8 halt, DA table
02 01 F0 78 FF 08 79 00 19 7A 11 7B 22 7C 33 7D
44 7E 55 E9 2A 3B FF 90 02 00 E0 70 FD EF 90 02
01 F0 EC 9D 2E 28 FF 90 02 00 E0 70 FD EF 90 02
01 F0 7A 05 EA FF 90 02 00 E0 70 FD EF 90 02 01
F0 DA F1 7B 03 90 00 DA EB 93 FF 90 02 00 E0 70
FD EF 90 02 01 F0 DB ED 80 FE 00 A5 5A C7 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// count
0F
// logic, rotate, add, subb, branch, registers
60 81 27 F6 06 33 44
// djnz countdown, then table entries 3, 2, 1
05 04 03 02 01 C7 5A A5
